// File: hw/dma_slot_pkg.sv
`default_nettype none

package dma_slot_pkg;

  // core and slot space
  localparam int CORE_COUNT = 16;
  localparam int SLOT_COUNT = 16;
  localparam int CORE_NO_W  = $clog2(CORE_COUNT);
  localparam int SLOT_NO_W  = $clog2(SLOT_COUNT);

  // slot base kept without its 8 leading zero bits
  localparam int SLOT_ADDR_W = 7;
  localparam logic [7:0] RX_WRITE_OFFSET = 8'h0A;

  localparam int ADDR_W = 20;
  localparam int LEN_W  = 16;
  localparam logic [LEN_W-1:0] DEF_MAX_PKT_LEN = 16'd2048;

  localparam int PORT_COUNT        = 2;
  localparam int MSG_W             = 64;
  localparam int PEND_W            = 10;
  localparam int FREE_FIFO_DEPTH_W = 8;

  typedef struct packed {
    logic [CORE_NO_W-1:0] core_no;
    logic [SLOT_NO_W-1:0] slot_no;
  } slot_ref_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [LEN_W-1:0]  len;
  } rx_desc_t;

endpackage

`default_nettype wire

// File: hw/slot_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module slot_fifo
  import dma_slot_pkg::*;
#(
  parameter type entry_t = slot_ref_t,
  parameter int  DEPTH_W = FREE_FIFO_DEPTH_W
) (
  input  logic   clk,
  input  logic   rst,
  input  logic   push,
  input  entry_t din,
  output logic   full,
  output logic   valid,
  output entry_t dout,
  input  logic   pop
);

  entry_t             mem [2**DEPTH_W];
  logic [DEPTH_W-1:0] wr_ptr;
  logic [DEPTH_W-1:0] rd_ptr;
  logic [DEPTH_W:0]   count;
  logic               do_push;
  logic               do_pop;

  // count reaches 2**DEPTH_W only when every entry is used
  assign full    = count[DEPTH_W];
  assign valid   = (count != '0);
  assign do_push = push && !full;
  assign do_pop  = pop && valid;

  // head entry shown directly
  assign dout = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/slot_lookup.sv
`timescale 1ns/1ps
`default_nettype none

module slot_lookup
  import dma_slot_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst,
  input  slot_ref_t              inject_slot,
  input  logic                   inject_valid,
  output logic                   inject_ready,
  input  slot_ref_t              ret_slot,
  input  logic                   ret_valid,
  input  logic [SLOT_NO_W-1:0]   slot_addr_wr_no,
  input  logic [SLOT_ADDR_W-1:0] slot_addr_wr_data,
  input  logic                   slot_addr_wr_valid,
  input  logic [CORE_COUNT-1:0]  drop_list,
  input  logic                   drop_list_valid,
  input  logic [LEN_W-1:0]       max_pkt_len,
  input  logic                   max_pkt_len_valid,
  output rx_desc_t               desc,
  output logic                   desc_valid,
  input  logic                   desc_take
);

  logic                   inject_en;
  logic                   fifo_push;
  logic                   fifo_full;
  logic                   fifo_valid;
  logic                   fifo_pop;
  slot_ref_t              fifo_din;
  slot_ref_t              fifo_head;
  logic [SLOT_ADDR_W-1:0] base_mem [SLOT_COUNT];
  logic                   head_valid_r;
  logic [CORE_NO_W-1:0]   head_core_r;
  logic [SLOT_ADDR_W-1:0] head_base_r;
  logic                   head_drop;
  logic [CORE_COUNT-1:0]  drop_list_r;
  logic [LEN_W-1:0]       max_len_r;

  // injection held off in the first cycle out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      inject_en <= 1'b0;
    end else begin
      inject_en <= 1'b1;
    end
  end

  // returned slots win the single write port
  assign inject_ready = inject_en && !ret_valid && !fifo_full;
  assign fifo_push    = ret_valid || (inject_valid && inject_ready);
  assign fifo_din     = ret_valid ? ret_slot : inject_slot;

  slot_fifo #(
    .entry_t (slot_ref_t),
    .DEPTH_W (FREE_FIFO_DEPTH_W)
  ) free_fifo (
    .clk   (clk),
    .rst   (rst),
    .push  (fifo_push),
    .din   (fifo_din),
    .full  (fifo_full),
    .valid (fifo_valid),
    .dout  (fifo_head),
    .pop   (fifo_pop)
  );

  // head stage, cleared for one cycle after each pop
  always_ff @(posedge clk) begin
    if (rst) begin
      head_valid_r <= 1'b0;
    end else begin
      head_valid_r <= fifo_valid && !fifo_pop;
    end
  end

  // base table read lines up with the registered head
  always_ff @(posedge clk) begin
    if (slot_addr_wr_valid) begin
      base_mem[slot_addr_wr_no] <= slot_addr_wr_data;
    end
    head_core_r <= fifo_head.core_no;
    head_base_r <= base_mem[fifo_head.slot_no];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      drop_list_r <= '0;
      max_len_r   <= DEF_MAX_PKT_LEN;
    end else begin
      if (drop_list_valid) begin
        drop_list_r <= drop_list;
      end
      if (max_pkt_len_valid) begin
        max_len_r <= max_pkt_len;
      end
    end
  end

  assign head_drop  = drop_list_r[head_core_r];
  // dropped heads leave without being offered
  assign fifo_pop   = head_valid_r && (head_drop || desc_take);
  assign desc_valid = head_valid_r && !head_drop;

  assign desc.addr = {head_core_r, 1'b0, head_base_r, RX_WRITE_OFFSET};
  assign desc.len  = max_len_r;

endmodule

`default_nettype wire

// File: hw/rx_port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rx_port_arbiter
  import dma_slot_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  rx_desc_t                     desc,
  input  logic                         desc_valid,
  output logic                         desc_take,
  input  logic [PORT_COUNT-1:0]        incoming_pkt_ready,
  input  logic [PORT_COUNT-1:0]        rx_desc_ready,
  output logic [PORT_COUNT*ADDR_W-1:0] rx_desc_addr,
  output logic [PORT_COUNT*LEN_W-1:0]  rx_desc_len,
  output logic [PORT_COUNT-1:0]        rx_desc_valid
);

  logic [PEND_W-1:0]     pend [PORT_COUNT];
  logic [PORT_COUNT-1:0] can_receive;
  logic                  port_sel;
  logic                  last_sel;

  // ready port with a packet waiting or arriving now
  always_comb begin
    for (int p = 0; p < PORT_COUNT; p++) begin
      can_receive[p] = desc_valid && rx_desc_ready[p] &&
                       ((pend[p] != '0) || incoming_pkt_ready[p]);
    end
  end

  // switch away from the last port whenever the other one can take it
  always_comb begin
    port_sel = last_sel;
    if (last_sel && can_receive[0]) begin
      port_sel = 1'b0;
    end else if (!last_sel && can_receive[1]) begin
      port_sel = 1'b1;
    end
  end

  // starts as if port 1 went last, so port 0 comes first
  always_ff @(posedge clk) begin
    if (rst) begin
      last_sel <= 1'b1;
    end else if (|rx_desc_valid) begin
      last_sel <= port_sel;
    end
  end

  assign rx_desc_valid[0] = can_receive[0] && !port_sel;
  assign rx_desc_valid[1] = can_receive[1] && port_sel;
  assign desc_take        = |rx_desc_valid;

  // an arrival in the serving cycle cancels the decrement
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int p = 0; p < PORT_COUNT; p++) begin
        pend[p] <= '0;
      end
    end else begin
      for (int p = 0; p < PORT_COUNT; p++) begin
        if (rx_desc_valid[p] && !incoming_pkt_ready[p]) begin
          pend[p] <= pend[p] - 1'b1;
        end else if (!rx_desc_valid[p] && incoming_pkt_ready[p]) begin
          pend[p] <= pend[p] + 1'b1;
        end
      end
    end
  end

  // same descriptor on every lane, valid picks the port
  assign rx_desc_addr = {PORT_COUNT{desc.addr}};
  assign rx_desc_len  = {PORT_COUNT{desc.len}};

endmodule

`default_nettype wire

// File: hw/tx_desc_forward.sv
`timescale 1ns/1ps
`default_nettype none

module tx_desc_forward
  import dma_slot_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  input  logic [PORT_COUNT*MSG_W-1:0]     msg_data,
  input  logic [PORT_COUNT-1:0]           msg_valid,
  input  logic [PORT_COUNT*CORE_NO_W-1:0] msg_core_no,
  output logic [PORT_COUNT-1:0]           msg_ready,
  output logic [PORT_COUNT*ADDR_W-1:0]    tx_desc_addr,
  output logic [PORT_COUNT*LEN_W-1:0]     tx_desc_len,
  output logic [PORT_COUNT-1:0]           tx_desc_valid,
  input  logic [PORT_COUNT-1:0]           tx_desc_ready,
  input  logic [PORT_COUNT-1:0]           pkt_sent_out_valid,
  output slot_ref_t                       ret_slot,
  output logic                            ret_valid
);

  logic [PORT_COUNT-1:0]            msg_drop;
  logic [PORT_COUNT-1:0]            accept;
  logic [PORT_COUNT-1:0]            sent_pop;
  logic [PORT_COUNT-1:0]            held_valid;
  slot_ref_t [PORT_COUNT-1:0]       held_slot;
  logic                             both_sent_r;

  for (genvar p = 0; p < PORT_COUNT; p++) begin : g_port
    logic [MSG_W-1:0]     msg;
    logic [CORE_NO_W-1:0] core_no;
    slot_ref_t            msg_slot;

    assign msg     = msg_data[p*MSG_W +: MSG_W];
    assign core_no = msg_core_no[p*CORE_NO_W +: CORE_NO_W];

    // zero length messages are swallowed
    assign msg_drop[p]      = (msg[LEN_W-1:0] == '0);
    assign msg_ready[p]     = tx_desc_ready[p] || msg_drop[p];
    assign tx_desc_valid[p] = msg_valid[p] && !msg_drop[p];
    assign accept[p]        = tx_desc_valid[p] && tx_desc_ready[p];

    assign tx_desc_len[p*LEN_W +: LEN_W]    = msg[LEN_W-1:0];
    assign tx_desc_addr[p*ADDR_W +: ADDR_W] = {core_no, msg[32 +: ADDR_W-CORE_NO_W]};

    // slot number lives in bits 31:24
    assign msg_slot = {core_no, msg[24 +: SLOT_NO_W]};

    // slot in flight until the MAC reports it sent
    slot_fifo #(
      .entry_t (slot_ref_t),
      .DEPTH_W (1)
    ) sent_fifo (
      .clk   (clk),
      .rst   (rst),
      .push  (accept[p]),
      .din   (msg_slot),
      .full  (),
      .valid (held_valid[p]),
      .dout  (held_slot[p]),
      .pop   (sent_pop[p])
    );
  end

  // port 1 waits a cycle when both ports report together
  assign sent_pop[0] = pkt_sent_out_valid[0];
  assign sent_pop[1] = (pkt_sent_out_valid[1] && !pkt_sent_out_valid[0]) || both_sent_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      both_sent_r <= 1'b0;
      ret_valid   <= 1'b0;
    end else begin
      both_sent_r <= &pkt_sent_out_valid;
      ret_valid   <= |(sent_pop & held_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (sent_pop[0] && held_valid[0]) begin
      ret_slot <= held_slot[0];
    end else begin
      ret_slot <= held_slot[1];
    end
  end

endmodule

`default_nettype wire

// File: hw/dma_slot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module dma_slot_ctrl
  import dma_slot_pkg::*;
(
  input  logic                            clk,
  input  logic                            rst,
  // slot setup
  input  logic [CORE_NO_W+SLOT_NO_W-1:0]  inject_slot,
  input  logic                            inject_valid,
  output logic                            inject_ready,
  input  logic [SLOT_NO_W-1:0]            slot_addr_wr_no,
  input  logic [SLOT_ADDR_W-1:0]          slot_addr_wr_data,
  input  logic                            slot_addr_wr_valid,
  input  logic [CORE_COUNT-1:0]           drop_list,
  input  logic                            drop_list_valid,
  input  logic [LEN_W-1:0]                max_pkt_len,
  input  logic                            max_pkt_len_valid,
  // MAC receive side
  input  logic [PORT_COUNT-1:0]           incoming_pkt_ready,
  input  logic [PORT_COUNT-1:0]           rx_desc_ready,
  output logic [PORT_COUNT*ADDR_W-1:0]    rx_desc_addr,
  output logic [PORT_COUNT*LEN_W-1:0]     rx_desc_len,
  output logic [PORT_COUNT-1:0]           rx_desc_valid,
  // core messages and MAC transmit side
  input  logic [PORT_COUNT*MSG_W-1:0]     msg_data,
  input  logic [PORT_COUNT-1:0]           msg_valid,
  input  logic [PORT_COUNT*CORE_NO_W-1:0] msg_core_no,
  output logic [PORT_COUNT-1:0]           msg_ready,
  output logic [PORT_COUNT*ADDR_W-1:0]    tx_desc_addr,
  output logic [PORT_COUNT*LEN_W-1:0]     tx_desc_len,
  output logic [PORT_COUNT-1:0]           tx_desc_valid,
  input  logic [PORT_COUNT-1:0]           tx_desc_ready,
  input  logic [PORT_COUNT-1:0]           pkt_sent_out_valid
);

  slot_ref_t ret_slot;
  logic      ret_valid;
  rx_desc_t  desc;
  logic      desc_valid;
  logic      desc_take;

  slot_lookup slot_lookup_i (
    .clk                (clk),
    .rst                (rst),
    .inject_slot        (inject_slot),
    .inject_valid       (inject_valid),
    .inject_ready       (inject_ready),
    .ret_slot           (ret_slot),
    .ret_valid          (ret_valid),
    .slot_addr_wr_no    (slot_addr_wr_no),
    .slot_addr_wr_data  (slot_addr_wr_data),
    .slot_addr_wr_valid (slot_addr_wr_valid),
    .drop_list          (drop_list),
    .drop_list_valid    (drop_list_valid),
    .max_pkt_len        (max_pkt_len),
    .max_pkt_len_valid  (max_pkt_len_valid),
    .desc               (desc),
    .desc_valid         (desc_valid),
    .desc_take          (desc_take)
  );

  rx_port_arbiter rx_port_arbiter_i (
    .clk                (clk),
    .rst                (rst),
    .desc               (desc),
    .desc_valid         (desc_valid),
    .desc_take          (desc_take),
    .incoming_pkt_ready (incoming_pkt_ready),
    .rx_desc_ready      (rx_desc_ready),
    .rx_desc_addr       (rx_desc_addr),
    .rx_desc_len        (rx_desc_len),
    .rx_desc_valid      (rx_desc_valid)
  );

  tx_desc_forward tx_desc_forward_i (
    .clk                (clk),
    .rst                (rst),
    .msg_data           (msg_data),
    .msg_valid          (msg_valid),
    .msg_core_no        (msg_core_no),
    .msg_ready          (msg_ready),
    .tx_desc_addr       (tx_desc_addr),
    .tx_desc_len        (tx_desc_len),
    .tx_desc_valid      (tx_desc_valid),
    .tx_desc_ready      (tx_desc_ready),
    .pkt_sent_out_valid (pkt_sent_out_valid),
    .ret_slot           (ret_slot),
    .ret_valid          (ret_valid)
  );

endmodule

`default_nettype wire

// File: dv/tb_dma_slot_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dma_slot_ctrl;

  logic         clk = 1'b0;
  logic         rst;
  logic [7:0]   inject_slot;
  logic         inject_valid;
  logic         inject_ready;
  logic [3:0]   slot_addr_wr_no;
  logic [6:0]   slot_addr_wr_data;
  logic         slot_addr_wr_valid;
  logic [15:0]  drop_list;
  logic         drop_list_valid;
  logic [15:0]  max_pkt_len;
  logic         max_pkt_len_valid;
  logic [1:0]   incoming_pkt_ready;
  logic [1:0]   rx_desc_ready;
  logic [39:0]  rx_desc_addr;
  logic [31:0]  rx_desc_len;
  logic [1:0]   rx_desc_valid;
  logic [127:0] msg_data;
  logic [1:0]   msg_valid;
  logic [7:0]   msg_core_no;
  logic [1:0]   msg_ready;
  logic [39:0]  tx_desc_addr;
  logic [31:0]  tx_desc_len;
  logic [1:0]   tx_desc_valid;
  logic [1:0]   tx_desc_ready;
  logic [1:0]   pkt_sent_out_valid;

  // reference model state
  logic [6:0]  base_tbl [16];
  logic [15:0] ref_len;
  logic [15:0] ref_drop;
  logic [7:0]  free_q [$];
  logic [7:0]  sent_q0 [$];
  logic [7:0]  sent_q1 [$];

  // operations read from the case file
  string       op_q [$];
  string       name_q [$];
  logic [63:0] a_q [$];
  logic [63:0] b_q [$];
  logic [63:0] c_q [$];
  logic [63:0] d_q [$];
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          checks = 0;

  dma_slot_ctrl dma_slot_ctrl_i (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      abort_run($sformatf("timeout after %0d cycles, the DUT stopped responding", cycle_count));
    end
  end

  task abort_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task check_value(input string name, input logic [63:0] expected, input logic [63:0] actual);
    checks = checks + 1;
    if (expected !== actual) begin
      abort_run($sformatf("ERR %s expected %0h actual %0h", name, expected, actual));
    end
  endtask

  task load_cases;
    int          fd;
    int          n;
    string       line;
    string       op;
    string       name;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] c;
    logic [63:0] d;
    fd = $fopen("dv/dma_slot_cases.txt", "r");
    if (fd == 0) begin
      abort_run("cannot open the case file dv/dma_slot_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // skip comment lines
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %s", op, a, b, c, d, name);
          if (n == 6) begin
            op_q.push_back(op);
            a_q.push_back(a);
            b_q.push_back(b);
            c_q.push_back(c);
            d_q.push_back(d);
            name_q.push_back(name);
          end else if (n > 0) begin
            abort_run("malformed line in the case file");
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // one-cycle strobe on a config input
  task write_config(input string op, input logic [63:0] a, input logic [63:0] b);
    @(posedge clk);
    if (op == "tbl") begin
      slot_addr_wr_no    <= a[3:0];
      slot_addr_wr_data  <= b[6:0];
      slot_addr_wr_valid <= 1'b1;
      base_tbl[a[3:0]] = b[6:0];
    end else if (op == "len") begin
      max_pkt_len       <= a[15:0];
      max_pkt_len_valid <= 1'b1;
      ref_len = a[15:0];
    end else if (op == "drop") begin
      drop_list       <= a[15:0];
      drop_list_valid <= 1'b1;
      ref_drop = a[15:0];
    end else if (op == "pkt") begin
      incoming_pkt_ready <= a[1:0];
    end else begin
      pkt_sent_out_valid <= a[1:0];
    end
    @(posedge clk);
    slot_addr_wr_valid <= 1'b0;
    max_pkt_len_valid  <= 1'b0;
    drop_list_valid    <= 1'b0;
    incoming_pkt_ready <= 2'b00;
    pkt_sent_out_valid <= 2'b00;
  endtask

  task inject_one(input logic [3:0] core, input logic [3:0] slot);
    @(posedge clk);
    inject_slot  <= {core, slot};
    inject_valid <= 1'b1;
    do @(negedge clk); while (!inject_ready);
    @(posedge clk);
    inject_valid <= 1'b0;
    free_q.push_back({core, slot});
  endtask

  // port 0 returns its slot before port 1
  task release_sent(input logic [1:0] mask);
    if ((mask[0] && sent_q0.size() == 0) || (mask[1] && sent_q1.size() == 0)) begin
      abort_run("sent-out pulse on a port with no packet in flight");
    end else begin
      if (mask[0]) free_q.push_back(sent_q0.pop_front());
      if (mask[1]) free_q.push_back(sent_q1.pop_front());
    end
  endtask

  task expect_rx(input logic [1:0] mask, input logic [0:0] port, input string name);
    logic [7:0]  ref_slot;
    logic [19:0] exp_addr;
    @(posedge clk);
    rx_desc_ready <= mask;
    do @(negedge clk); while (rx_desc_valid == 2'b00);
    // dropped cores never reach a port
    while (free_q.size() > 0 && ref_drop[free_q[0][7:4]]) begin
      ref_slot = free_q.pop_front();
    end
    if (free_q.size() == 0) begin
      abort_run("receive descriptor issued while no free slot was expected");
    end else begin
      ref_slot = free_q.pop_front();
      exp_addr = {ref_slot[7:4], 1'b0, base_tbl[ref_slot[3:0]], 8'h0A};
      check_value({name, ".valid"}, 2'b01 << port, rx_desc_valid);
      check_value({name, ".addr"}, exp_addr, rx_desc_addr[port*20 +: 20]);
      check_value({name, ".len"}, ref_len, rx_desc_len[port*16 +: 16]);
    end
    @(posedge clk);
    rx_desc_ready <= 2'b00;
  endtask

  task send_msg(input logic [0:0] port, input logic [3:0] core, input logic [63:0] data,
                input logic exp_valid, input string name);
    @(posedge clk);
    msg_data[port*64 +: 64]  <= data;
    msg_core_no[port*4 +: 4] <= core;
    msg_valid[port]          <= 1'b1;
    // MAC not ready while a message is swallowed
    tx_desc_ready[port]      <= exp_valid;
    @(negedge clk);
    check_value({name, ".valid"}, exp_valid, tx_desc_valid[port]);
    check_value({name, ".ready"}, 1'b1, msg_ready[port]);
    if (exp_valid) begin
      check_value({name, ".addr"}, {core, data[47:32]}, tx_desc_addr[port*20 +: 20]);
      check_value({name, ".len"}, data[15:0], tx_desc_len[port*16 +: 16]);
      if (port == 1'b0) sent_q0.push_back({core, data[27:24]});
      else sent_q1.push_back({core, data[27:24]});
    end
    @(posedge clk);
    msg_valid[port]     <= 1'b0;
    tx_desc_ready[port] <= 1'b1;
  endtask

  initial begin
    rst                <= 1'b1;
    inject_slot        <= '0;
    inject_valid       <= 1'b0;
    slot_addr_wr_no    <= '0;
    slot_addr_wr_data  <= '0;
    slot_addr_wr_valid <= 1'b0;
    drop_list          <= '0;
    drop_list_valid    <= 1'b0;
    max_pkt_len        <= '0;
    max_pkt_len_valid  <= 1'b0;
    incoming_pkt_ready <= 2'b00;
    rx_desc_ready      <= 2'b00;
    msg_data           <= '0;
    msg_valid          <= 2'b00;
    msg_core_no        <= '0;
    tx_desc_ready      <= 2'b11;
    pkt_sent_out_valid <= 2'b00;
    ref_len  = 16'd2048;
    ref_drop = '0;
    load_cases();
    cycle_limit = 200 * op_q.size();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // inject port stays closed for the first cycle out of reset
    @(negedge clk);
    check_value("reset_inject_ready_low", 1'b0, inject_ready);
    @(negedge clk);
    check_value("reset_inject_ready_high", 1'b1, inject_ready);
    foreach (op_q[i]) begin
      if (op_q[i] == "inj") begin
        inject_one(a_q[i][3:0], b_q[i][3:0]);
      end else if (op_q[i] == "rx") begin
        expect_rx(a_q[i][1:0], b_q[i][0], name_q[i]);
      end else if (op_q[i] == "msg") begin
        send_msg(a_q[i][0], b_q[i][3:0], c_q[i], d_q[i][0], name_q[i]);
      end else if (op_q[i] == "sent") begin
        write_config(op_q[i], a_q[i], b_q[i]);
        release_sent(a_q[i][1:0]);
      end else begin
        write_config(op_q[i], a_q[i], b_q[i]);
      end
    end
    if (checks == 0) begin
      abort_run("no checks were made, the case file holds no receive or message lines");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: dv/dma_slot_cases.txt
# each line holds op a b c d name with a to d in hex
# tbl slot base / len length / drop core mask / inj core slot / pkt and sent port mask / rx ready mask and port / msg port core message tx valid
tbl  3   25 0                0 tbl_slot3
tbl  5   7f 0                0 tbl_slot5
tbl  7   3c 0                0 tbl_slot7
tbl  9   01 0                0 tbl_slot9
tbl  a   11 0                0 tbl_slot10
pkt  3   0  0                0 pend_both_a
pkt  3   0  0                0 pend_both_b
inj  2   3  0                0 inj_c2_s3
rx   3   0  0                0 rx_first_port0
inj  4   5  0                0 inj_c4_s5
rx   3   1  0                0 rx_alt_port1
len  5dc 0  0                0 len_1500
inj  1   9  0                0 inj_c1_s9
rx   3   0  0                0 rx_len_port0
drop 44  0  0                0 drop_c2_c6
inj  2   5  0                0 inj_c2_dropped
inj  6   3  0                0 inj_c6_dropped
inj  7   9  0                0 inj_c7_s9
inj  8   3  0                0 inj_c8_s3
pkt  1   0  0                0 pend_port0
rx   3   1  0                0 rx_skip_drop_port1
rx   1   0  0                0 rx_only_port0
drop 0   0  0                0 drop_clear
msg  0   2  0000456707000040 1 msg_p0_c2
msg  1   b  000089ab0a000000 0 msg_p1_zero_len
msg  1   b  000089ab0a000100 1 msg_p1_c11
sent 3   0  0                0 sent_both
pkt  3   0  0                0 pend_both_c
rx   3   1  0                0 rx_ret_c2_port1
rx   3   0  0                0 rx_ret_c11_port0

// File: list.f
hw/dma_slot_pkg.sv
hw/slot_fifo.sv
hw/slot_lookup.sv
hw/rx_port_arbiter.sv
hw/tx_desc_forward.sv
hw/dma_slot_ctrl.sv
dv/tb_dma_slot_ctrl.sv
